// ==== rtl/mipsPkg.sv ====
// MIPS execute stage shared constants, opcode and function encodings, ALU operation set
package mipsPkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int DataWidth    = 32; // Register and datapath width
  localparam int RegAddrWidth = 5;  // 32 architectural registers

  // ----------------------------------------------------------
  // Primary opcodes, instr[31:26]
  // ----------------------------------------------------------
  localparam logic [5:0] OpRType = 6'h00; // Function field selects the operation
  localparam logic [5:0] OpAddi  = 6'h08;
  localparam logic [5:0] OpAddiu = 6'h09;
  localparam logic [5:0] OpSlti  = 6'h0A;
  localparam logic [5:0] OpAndi  = 6'h0C;
  localparam logic [5:0] OpOri   = 6'h0D;
  localparam logic [5:0] OpXori  = 6'h0E;
  localparam logic [5:0] OpLui   = 6'h0F;

  // ----------------------------------------------------------
  // R-type function codes, instr[5:0]
  // ----------------------------------------------------------
  // Shifts by the shamt field
  localparam logic [5:0] FnSll  = 6'h00;
  localparam logic [5:0] FnSrl  = 6'h02;
  localparam logic [5:0] FnSra  = 6'h03;

  // Arithmetic, no overflow trap on ADD or SUB
  localparam logic [5:0] FnAdd  = 6'h20;
  localparam logic [5:0] FnAddu = 6'h21;
  localparam logic [5:0] FnSub  = 6'h22;
  localparam logic [5:0] FnSubu = 6'h23;

  // Logic and compare
  localparam logic [5:0] FnAnd  = 6'h24;
  localparam logic [5:0] FnOr   = 6'h25;
  localparam logic [5:0] FnXor  = 6'h26;
  localparam logic [5:0] FnNor  = 6'h27;
  localparam logic [5:0] FnSlt  = 6'h2A;
  localparam logic [5:0] FnSltu = 6'h2B;

  // ----------------------------------------------------------
  // ALU operations
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    AluAdd  = 4'd0,
    AluSub  = 4'd1,
    AluAnd  = 4'd2,
    AluOr   = 4'd3,
    AluXor  = 4'd4,
    AluNor  = 4'd5,
    AluSlt  = 4'd6,  // Signed compare
    AluSltu = 4'd7,  // Unsigned compare
    AluSll  = 4'd8,
    AluSrl  = 4'd9,
    AluSra  = 4'd10, // Shift in copies of the sign bit
    AluLui  = 4'd11  // Low half of b moved to the upper half
  } aluOpT;

endpackage

// ==== rtl/regFile.sv ====
// Register file with hard-wired zero entry, two asynchronous read ports and one clocked write port
`timescale 1ns/1ps

module regFile #(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 5
) (
  input  logic                 clk,
  input  logic                 reset,

  // Read ports, combinational
  input  logic [AddrWidth-1:0] readAddr1,
  input  logic [AddrWidth-1:0] readAddr2,
  output logic [DataWidth-1:0] readData1,
  output logic [DataWidth-1:0] readData2,

  // Write port, takes effect on the rising edge
  input  logic [AddrWidth-1:0] writeAddr,
  input  logic                 writeEn,
  input  logic [DataWidth-1:0] writeData
);

  localparam int Depth = 2 ** AddrWidth;

  logic [DataWidth-1:0] regs [Depth];

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // Entry 0 has no flop behind it, writes to it are simply lost
  assign regs[0] = '0;

  for (genvar i = 1; i < Depth; i++) begin : gEntry
    logic hit; // Write decode for this entry

    assign hit = writeEn && (writeAddr == AddrWidth'(i));

    always_ff @(posedge clk) begin
      if (reset) begin
        regs[i] <= '0;
      end else if (hit) begin
        regs[i] <= writeData;
      end
    end
  end

  // ----------------------------------------------------------
  // Read multiplexers
  // ----------------------------------------------------------
  // A write in this cycle is seen only after the edge, so a
  // reader in the next cycle gets the new value

  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

endmodule

// ==== rtl/instrDecoder.sv ====
// Instruction decoder, splits the word into fields and drives ALU, operand and write controls
`timescale 1ns/1ps

module instrDecoder #(
  parameter int RegAddrWidth = 5
) (
  input  logic                    instrValid,
  input  logic [31:0]             instr,

  // Register addresses
  output logic [RegAddrWidth-1:0] rs,
  output logic [RegAddrWidth-1:0] rt,
  output logic [RegAddrWidth-1:0] writeReg,

  // Execute controls
  output mipsPkg::aluOpT          aluOp,
  output logic [4:0]              shamt,
  output logic                    useImm,
  output logic [31:0]             immValue,

  // Write-back and status
  output logic                    writeEn,
  output logic                    illegal
);

  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [RegAddrWidth-1:0] rd;
  logic [15:0]             imm;

  logic zeroExtImm; // ANDI, ORI, XORI and LUI take the immediate unsigned
  logic destIsRd;   // R-type writes rd, I-type writes rt
  logic legal;

  // ----------------------------------------------------------
  // Field extraction
  // ----------------------------------------------------------
  assign opcode = instr[31:26];
  assign rs     = instr[21 +: RegAddrWidth];
  assign rt     = instr[16 +: RegAddrWidth];
  assign rd     = instr[11 +: RegAddrWidth];
  assign shamt  = instr[10:6];
  assign funct  = instr[5:0];
  assign imm    = instr[15:0];

  // ----------------------------------------------------------
  // Operation decode
  // ----------------------------------------------------------
  always_comb begin
    aluOp      = mipsPkg::AluAdd;
    useImm     = 1'b1;
    zeroExtImm = 1'b0;
    destIsRd   = 1'b0;
    legal      = 1'b1;

    case (opcode)
      mipsPkg::OpRType: begin
        useImm   = 1'b0;
        destIsRd = 1'b1;
        case (funct)
          mipsPkg::FnAdd, mipsPkg::FnAddu: aluOp = mipsPkg::AluAdd; // Both wrap
          mipsPkg::FnSub, mipsPkg::FnSubu: aluOp = mipsPkg::AluSub;
          mipsPkg::FnAnd:  aluOp = mipsPkg::AluAnd;
          mipsPkg::FnOr:   aluOp = mipsPkg::AluOr;
          mipsPkg::FnXor:  aluOp = mipsPkg::AluXor;
          mipsPkg::FnNor:  aluOp = mipsPkg::AluNor;
          mipsPkg::FnSlt:  aluOp = mipsPkg::AluSlt;
          mipsPkg::FnSltu: aluOp = mipsPkg::AluSltu;
          mipsPkg::FnSll:  aluOp = mipsPkg::AluSll;
          mipsPkg::FnSrl:  aluOp = mipsPkg::AluSrl;
          mipsPkg::FnSra:  aluOp = mipsPkg::AluSra;
          default:         legal = 1'b0;
        endcase
      end
      mipsPkg::OpAddi, mipsPkg::OpAddiu: aluOp = mipsPkg::AluAdd;
      mipsPkg::OpSlti: aluOp = mipsPkg::AluSlt;
      mipsPkg::OpAndi: begin
        aluOp      = mipsPkg::AluAnd;
        zeroExtImm = 1'b1;
      end
      mipsPkg::OpOri: begin
        aluOp      = mipsPkg::AluOr;
        zeroExtImm = 1'b1;
      end
      mipsPkg::OpXori: begin
        aluOp      = mipsPkg::AluXor;
        zeroExtImm = 1'b1;
      end
      mipsPkg::OpLui: begin
        aluOp      = mipsPkg::AluLui;
        zeroExtImm = 1'b1;
      end
      default: legal = 1'b0; // Loads, stores, branches and the rest
    endcase
  end

  // Immediate extension and destination select
  assign immValue = zeroExtImm ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign writeReg = destIsRd ? rd : rt;

  assign writeEn = instrValid & legal;
  assign illegal = instrValid & ~legal;

endmodule

// ==== rtl/alu.sv ====
// Combinational ALU for add, subtract, logic, set-less-than, shifts and upper-immediate load
`timescale 1ns/1ps

module alu #(
  parameter int DataWidth = 32
) (
  input  mipsPkg::aluOpT       aluOp,
  input  logic [DataWidth-1:0] a,
  input  logic [DataWidth-1:0] b,
  input  logic [4:0]           shamt,
  output logic [DataWidth-1:0] result
);

  localparam int HalfWidth = DataWidth / 2;

  logic signedLess;
  logic unsignedLess;

  // ----------------------------------------------------------
  // Compare
  // ----------------------------------------------------------
  assign signedLess   = $signed(a) < $signed(b);
  assign unsignedLess = a < b;

  // ----------------------------------------------------------
  // Operation select
  // ----------------------------------------------------------
  always_comb begin
    case (aluOp)
      mipsPkg::AluAdd:  result = a + b; // Carry out dropped
      mipsPkg::AluSub:  result = a - b;
      mipsPkg::AluAnd:  result = a & b;
      mipsPkg::AluOr:   result = a | b;
      mipsPkg::AluXor:  result = a ^ b;
      mipsPkg::AluNor:  result = ~(a | b);

      // Set on less than, result is 1 or 0
      mipsPkg::AluSlt:  result = DataWidth'(signedLess);
      mipsPkg::AluSltu: result = DataWidth'(unsignedLess);

      // Shifts work on b only, a is the unused rs field
      mipsPkg::AluSll:  result = b << shamt;
      mipsPkg::AluSrl:  result = b >> shamt;
      mipsPkg::AluSra:  result = $unsigned($signed(b) >>> shamt);

      mipsPkg::AluLui:  result = {b[HalfWidth-1:0], {HalfWidth{1'b0}}};
      default:          result = '0;
    endcase
  end

endmodule

// ==== rtl/executeStage.sv ====
// Single-issue integer execute stage, decode, register read, ALU and write-back in one cycle
`timescale 1ns/1ps

module executeStage #(
  parameter int DataWidth    = mipsPkg::DataWidth,
  parameter int RegAddrWidth = mipsPkg::RegAddrWidth
) (
  input  logic                    clk,
  input  logic                    reset,

  // Instruction in, one per strobe
  input  logic                    instrValid,
  input  logic [31:0]             instr,

  // Registered result, one cycle after acceptance
  output logic                    resultValid,
  output logic [DataWidth-1:0]    resultData,
  output logic [RegAddrWidth-1:0] resultDest,
  output logic                    illegalInstr
);

  logic [RegAddrWidth-1:0] rs;
  logic [RegAddrWidth-1:0] rt;
  logic [RegAddrWidth-1:0] writeReg;
  mipsPkg::aluOpT          aluOp;
  logic [4:0]              shamt;
  logic                    useImm;
  logic [31:0]             immValue;
  logic                    writeEn;
  logic                    illegal;

  logic [DataWidth-1:0] readData1;
  logic [DataWidth-1:0] readData2;
  logic [DataWidth-1:0] operandB;
  logic [DataWidth-1:0] result;

  // ----------------------------------------------------------
  // Decode, register read, execute
  // ----------------------------------------------------------
  instrDecoder #(
    .RegAddrWidth(RegAddrWidth)
  ) i_instrDecoder (
    .instrValid(instrValid),
    .instr     (instr),
    .rs        (rs),
    .rt        (rt),
    .writeReg  (writeReg),
    .aluOp     (aluOp),
    .shamt     (shamt),
    .useImm    (useImm),
    .immValue  (immValue),
    .writeEn   (writeEn),
    .illegal   (illegal)
  );

  // Write-back lands at the accepting edge
  regFile #(
    .DataWidth(DataWidth),
    .AddrWidth(RegAddrWidth)
  ) i_regFile (
    .clk      (clk),
    .reset    (reset),
    .readAddr1(rs),
    .readAddr2(rt),
    .readData1(readData1),
    .readData2(readData2),
    .writeAddr(writeReg),
    .writeEn  (writeEn),
    .writeData(result)
  );

  assign operandB = useImm ? DataWidth'(immValue) : readData2; // Immediate or rt

  alu #(
    .DataWidth(DataWidth)
  ) i_alu (
    .aluOp (aluOp),
    .a     (readData1),
    .b     (operandB),
    .shamt (shamt),
    .result(result)
  );

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid  <= 1'b0;
      illegalInstr <= 1'b0;
    end else begin
      resultValid  <= writeEn;
      illegalInstr <= illegal;
    end
  end

  // Payload follows the legal instruction, destination 0 included
  always_ff @(posedge clk) begin
    if (writeEn) begin
      resultData <= result;
      resultDest <= writeReg;
    end
  end

endmodule

// ==== sim/executeStage_asserts.sv ====
// Bound timing checks on the execute stage result and illegal strobes
`timescale 1ns/1ps

module executeStage_asserts (
  input logic clk,
  input logic reset,
  input logic writeEn,
  input logic resultValid,
  input logic illegalInstr
);

  int failCount = 0; // Count of failed assertions

  // ------------------------------------------------------------
  // Strobe timing
  // ------------------------------------------------------------
  assert property (@(posedge clk) disable iff (reset) writeEn |=> resultValid)
    else begin
      $error("resultValid missing one cycle after a legal instruction");
      failCount++;
    end

  // No result without a legal instruction one cycle before
  assert property (@(posedge clk) disable iff (reset) !writeEn |=> !resultValid)
    else begin
      $error("resultValid without a legal instruction");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (reset) !(resultValid && illegalInstr))
    else begin
      $error("resultValid and illegalInstr high together");
      failCount++;
    end

  // Both strobes clear straight after reset
  assert property (@(posedge clk) reset |=> (!resultValid && !illegalInstr))
    else begin
      $error("Strobes not low after reset");
      failCount++;
    end

endmodule

bind executeStage executeStage_asserts i_executeStageAsserts (
  .clk         (clk),
  .reset       (reset),
  .writeEn     (writeEn),
  .resultValid (resultValid),
  .illegalInstr(illegalInstr)
);

// ==== sim/executeStageTb.sv ====
// Testbench for the execute stage, replays instruction and expected-result lines from a data file
`timescale 1ns/1ps

module executeStageTb;

  localparam int DataWidth    = mipsPkg::DataWidth;
  localparam int RegAddrWidth = mipsPkg::RegAddrWidth;
  localparam int MaxLines     = 64;
  localparam int Fields       = 4;  // instr, data, dest, illegal
  localparam int ResetCycles  = 4;
  localparam int WaitLimit    = 20; // Cycles allowed for any wait loop

  logic                    clk;
  logic                    reset;
  logic                    instrValid;
  logic [31:0]             instr;
  logic                    resultValid;
  logic [DataWidth-1:0]    resultData;
  logic [RegAddrWidth-1:0] resultDest;
  logic                    illegalInstr;

  logic [31:0] testData [MaxLines*Fields]; // Flat, four words per line
  int          lineCount;

  executeStage #(
    .DataWidth   (DataWidth),
    .RegAddrWidth(RegAddrWidth)
  ) i_executeStage (
    .clk         (clk),
    .reset       (reset),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .resultData  (resultData),
    .resultDest  (resultDest),
    .illegalInstr(illegalInstr)
  );

  // ------------------------------------------------------------
  // Clock and reset
  // ------------------------------------------------------------
  initial clk = 1'b0;
  always #2 clk = ~clk; // 4 ns period

  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #0.5;
    reset = 1'b0;
  end

  // ------------------------------------------------------------
  // Reporting and checks
  // ------------------------------------------------------------
  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      reportFailure($sformatf("MISMATCH at %0.1f ns: %s is %h, expected %h",
                              $realtime, name, actual, expected));
    end
  endtask

  // Outputs of line idx, one cycle after it was accepted
  task automatic checkOutputs(input int idx);
    logic expIllegal;
    expIllegal = testData[idx*Fields+3][0];
    compareValue("resultValid", resultValid, !expIllegal);
    compareValue("illegalInstr", illegalInstr, expIllegal);
    if (!expIllegal) begin // Payload holds its old value on an illegal word
      compareValue("resultData", resultData, testData[idx*Fields+1]);
      compareValue("resultDest", resultDest, testData[idx*Fields+2]);
    end
  endtask

  // ------------------------------------------------------------
  // Wait loops
  // ------------------------------------------------------------
  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0) begin
      if (cycles >= WaitLimit) begin
        reportFailure("Reset was never released");
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  task automatic drainPipeline();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #0.5;
    while (resultValid || illegalInstr) begin
      if (cycles >= WaitLimit) begin
        reportFailure("Outputs stayed active after the last instruction");
      end else begin
        @(posedge clk);
        #0.5;
        cycles++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    instrValid = 1'b0;
    instr      = '0;
    lineCount  = 0;

    $readmemh("sim/executeStage_testdata.txt", testData);
    while (lineCount < MaxLines && !$isunknown(testData[lineCount*Fields])) begin
      lineCount++;
    end
    if (lineCount == 0) begin
      reportFailure("No test lines could be read from the data file");
    end

    waitForReset();

    // One instruction per cycle, the previous one is checked first
    for (int i = 0; i < lineCount; i++) begin
      @(posedge clk);
      #0.5;
      if (i > 0) begin
        checkOutputs(i - 1);
      end
      instrValid = 1'b1;
      instr      = testData[i*Fields];
    end

    @(posedge clk);
    #0.5;
    checkOutputs(lineCount - 1);
    instrValid = 1'b0;
    instr      = '0;
    drainPipeline();

    if (i_executeStage.i_executeStageAsserts.failCount == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      reportFailure("Bound assertions failed during the run");
    end
  end

endmodule

// ==== sim/executeStage_testdata.txt ====
// Columns: instruction word, expected resultData, expected resultDest, expected illegal flag
// Lines run back to back, one per cycle, starting right after reset
00A00825 00000000 01 0  // or   $1, $5, $0
02201025 00000000 02 0  // or   $2, $17, $0
03E01825 00000000 03 0  // or   $3, $31, $0
2001FFFB FFFFFFFB 01 0  // addi  $1, $0, -5
34028001 00008001 02 0  // ori   $2, $0, 0x8001
3C031234 12340000 03 0  // lui   $3, 0x1234
34635678 12345678 03 0  // ori   $3, $3, 0x5678
24047FFF 00007FFF 04 0  // addiu $4, $0, 0x7fff
3C058000 80000000 05 0  // lui   $5, 0x8000
00203025 FFFFFFFB 06 0  // or    $6, $1, $0
00403825 00008001 07 0  // or    $7, $2, $0
24080001 00000001 08 0  // addiu $8, $0, 1
25080001 00000002 08 0  // addiu $8, $8, 1
25080001 00000003 08 0  // addiu $8, $8, 1
01084820 00000006 09 0  // add   $9, $8, $8
00A15021 7FFFFFFB 0A 0  // addu  $10, $5, $1
00A55820 00000000 0B 0  // add   $11, $5, $5
01096022 FFFFFFFD 0C 0  // sub   $12, $8, $9
00A86823 7FFFFFFD 0D 0  // subu  $13, $5, $8
00647024 00005678 0E 0  // and   $14, $3, $4
00A47825 80007FFF 0F 0  // or    $15, $5, $4
00618026 EDCBA983 10 0  // xor   $16, $3, $1
00448827 FFFF0000 11 0  // nor   $17, $2, $4
0028902A 00000001 12 0  // slt   $18, $1, $8
0028982B 00000000 13 0  // sltu  $19, $1, $8
0101A02A 00000000 14 0  // slt   $20, $8, $1
0101A82B 00000001 15 0  // sltu  $21, $8, $1
2836FFFC 00000001 16 0  // slti  $22, $1, -4
0001B900 FFFFFFB0 17 0  // sll   $23, $1, 4
0001C102 0FFFFFFF 18 0  // srl   $24, $1, 4
0001C843 FFFFFFFD 19 0  // sra   $25, $1, 1
383AFFFF FFFF0004 1A 0  // xori  $26, $1, 0xffff
303BFFF0 0000FFF0 1B 0  // andi  $27, $1, 0xfff0
24001234 00001234 00 0  // addiu $0, $0, 0x1234
0000E025 00000000 1C 0  // or    $28, $0, $0
8C030010 00000000 00 1  // lw    $3, 16($0)
00211818 00000000 00 1  // funct 0x18 aimed at $3
0060E825 12345678 1D 0  // or    $29, $3, $0

// ==== sim.f ====
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/alu.sv
rtl/executeStage.sv
sim/executeStage_asserts.sv
sim/executeStageTb.sv

// ==== Bender.yml ====
package:
  name: execute_stage

sources:
  # Design
  - rtl/mipsPkg.sv
  - rtl/regFile.sv
  - rtl/instrDecoder.sv
  - rtl/alu.sv
  - rtl/executeStage.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/executeStage_asserts.sv
      - sim/executeStageTb.sv
